// File: test/mul_testdata.txt
# funct3 word src_a src_b expected, all hex
# funct3 0..3 = MUL MULH MULHSU MULHU, word 1 with funct3 0 = MULW
0 0 0000000000000000 0000000000000000 0000000000000000
0 0 0000000000000003 0000000000000005 000000000000000f
0 0 ffffffffffffffff ffffffffffffffff 0000000000000001
0 0 ffffffffffffffff 0000000000000007 fffffffffffffff9
0 0 fffffffffffffffd 0000000000000005 fffffffffffffff1
0 0 123456789abcdef0 0000000000000000 0000000000000000
0 0 0000000100000000 0000000100000000 0000000000000000
0 0 00000000ffffffff 00000000ffffffff fffffffe00000001
0 0 8000000000000000 0000000000000002 0000000000000000
0 0 7fffffffffffffff 7fffffffffffffff 0000000000000001
0 0 123456789abcdef0 0000000000000003 369d0369d0369cd0
0 0 0123456789abcdef 0000000000000100 23456789abcdef00
0 0 ffffffffffffffff 8000000000000000 8000000000000000
1 0 8000000000000000 8000000000000000 4000000000000000
1 0 ffffffffffffffff ffffffffffffffff 0000000000000000
1 0 ffffffffffffffff 0000000000000001 ffffffffffffffff
1 0 7fffffffffffffff 7fffffffffffffff 3fffffffffffffff
1 0 8000000000000000 7fffffffffffffff c000000000000000
1 0 0000000100000000 0000000100000000 0000000000000001
1 0 ffffffff00000000 0000000100000000 ffffffffffffffff
1 0 0000000000000000 8000000000000000 0000000000000000
1 0 0000000000000003 0000000000000005 0000000000000000
1 0 fffffffffffffffd 0000000000000005 ffffffffffffffff
2 0 ffffffffffffffff ffffffffffffffff ffffffffffffffff
2 0 0000000000000001 ffffffffffffffff 0000000000000000
2 0 8000000000000000 8000000000000000 c000000000000000
2 0 0000000000000002 ffffffffffffffff 0000000000000001
2 0 fffffffffffffffe 8000000000000000 ffffffffffffffff
2 0 7fffffffffffffff ffffffffffffffff 7ffffffffffffffe
3 0 ffffffffffffffff ffffffffffffffff fffffffffffffffe
3 0 8000000000000000 8000000000000000 4000000000000000
3 0 8000000000000000 0000000000000002 0000000000000001
3 0 00000000ffffffff 00000000ffffffff 0000000000000000
3 0 ffffffffffffffff 0000000000000002 0000000000000001
3 0 ffffffffffffffff 0000000000000001 0000000000000000
0 1 deadbeef00000003 cafebabe00000005 000000000000000f
0 1 12345678ffffffff abcdef0000000007 fffffffffffffff9
0 1 5555555580000000 aaaaaaaa00000002 0000000000000000
0 1 ffffffff40000000 0123456700000002 ffffffff80000000
0 1 0f0f0f0f0000ffff f0f0f0f00000ffff fffffffffffe0001
0 1 1111111100001234 2222222200000010 0000000000012340
0 1 ffffffff7fffffff 0000000080000000 ffffffff80000000
1 1 ffff000000000003 1234000000000005 000000000000000f

// File: all.f
logic/mul_pkg.sv
logic/mul_decode.sv
logic/booth_mul.sv
logic/mul_result.sv
logic/mul_unit.sv
test/tb_mul_unit.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the mul_unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_mul_unit -o sim_mul_unit

out=$(./obj_dir/sim_mul_unit)
echo "$out"

if echo "$out" | grep -qx "TEST OK"; then
	exit 0
else
	exit 1
fi

// File: test/tb_mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mul_unit;

	localparam int XLEN     = 64;
	localparam int LATENCY  = XLEN / 2 + 3; // K booth steps, operand load, result register
	localparam int TIMEOUT  = 100;
	localparam int HOLD     = 10;
	localparam int BUSY_HIT = 10;           // cycle of the start that must be ignored
	localparam int MAX_READ = 1000;

	logic              clk;
	logic              rst_n;
	logic              start;
	mul_pkg::mul_req_t req;
	logic [XLEN-1:0]   src_a;
	logic [XLEN-1:0]   src_b;
	logic              busy;
	logic              done;
	logic [XLEN-1:0]   result;

	int errors;
	int checks;
	int cases;
	bit timed_out;

	mul_unit #(
		.XLEN (XLEN)
	) dut (
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (start),
		.req    (req),
		.src_a  (src_a),
		.src_b  (src_b),
		.busy   (busy),
		.done   (done),
		.result (result)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// inputs change and outputs are read 2 ns after the edge
	task automatic next_cycle;
		@(posedge clk);
		#2;
	endtask

	task automatic run_case(input int n, input logic [2:0] f3, input logic w,
			input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
			input logic [XLEN-1:0] expected);
		int cycles;
		int i;
		start      = 1'b1;
		req.funct3 = f3;
		req.word   = w;
		src_a      = a;
		src_b      = b;
		next_cycle(); // accepting edge
		start  = 1'b0;
		cycles = 0;
		while (done !== 1'b1 && cycles < TIMEOUT) begin
			if (cycles == BUSY_HIT) begin
				start      = 1'b1; // a different op while busy
				req.funct3 = f3 ^ 3'b011;
				req.word   = ~w;
				src_a      = ~a;
				src_b      = ~b;
			end else begin
				start      = 1'b0;
				req.funct3 = f3;
				req.word   = w;
				src_a      = a;
				src_b      = b;
			end
			checks++;
			if (busy !== 1'b1) begin
				errors++;
				$display("FAILED busy case %0d cycle %0d: expected %h got %h",
					n, cycles, 1'b1, busy);
			end
			next_cycle();
			cycles++;
		end
		start = 1'b0;
		if (done !== 1'b1) begin
			errors++;
			timed_out = 1'b1;
			$display("case %0d: done did not arrive within %0d cycles", n, TIMEOUT);
		end else begin
			checks++;
			if (cycles != LATENCY) begin
				errors++;
				$display("FAILED done latency case %0d: expected %h got %h", n, LATENCY, cycles);
			end
			checks++;
			if (busy !== 1'b1) begin
				errors++;
				$display("FAILED busy case %0d at done: expected %h got %h", n, 1'b1, busy);
			end
			checks++;
			if (result !== expected) begin
				errors++;
				$display("FAILED result case %0d: expected %h got %h", n, expected, result);
			end
			// idle afterwards, result must hold
			for (i = 0; i < HOLD; i++) begin
				next_cycle();
				checks++;
				if (done !== 1'b0) begin
					errors++;
					$display("FAILED done case %0d idle %0d: expected %h got %h",
						n, i, 1'b0, done);
				end
				checks++;
				if (busy !== 1'b0) begin
					errors++;
					$display("FAILED busy case %0d idle %0d: expected %h got %h",
						n, i, 1'b0, busy);
				end
				checks++;
				if (result !== expected) begin
					errors++;
					$display("FAILED result case %0d idle %0d: expected %h got %h",
						n, i, expected, result);
				end
			end
		end
	endtask

	initial begin
		int               fd;
		int               n;
		int               got;
		int               reads;
		bit               at_end;
		logic [2:0]       f3;
		logic             w;
		logic [XLEN-1:0]  a;
		logic [XLEN-1:0]  b;
		logic [XLEN-1:0]  expected;
		logic [8*256-1:0] rest;
		errors    = 0;
		checks    = 0;
		cases     = 0;
		timed_out = 1'b0;
		rst_n     = 1'b0;
		start     = 1'b0;
		req       = '0;
		src_a     = '0;
		src_b     = '0;
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;
		next_cycle();
		checks++;
		if (busy !== 1'b0 || done !== 1'b0 || result !== '0) begin
			errors++;
			$display("FAILED busy/done/result after reset: expected %h/%h/%h got %h/%h/%h",
				1'b0, 1'b0, {XLEN{1'b0}}, busy, done, result);
		end

		fd = $fopen("test/mul_testdata.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open test/mul_testdata.txt");
		end else begin
			at_end = 1'b0;
			reads  = 0;
			while (!at_end && !timed_out && reads < MAX_READ) begin
				reads++;
				n = $fscanf(fd, "%h %h %h %h %h", f3, w, a, b, expected);
				if (n == 5) begin
					cases++;
					run_case(cases, f3, w, a, b, expected);
				end else if ($feof(fd) != 0) begin
					at_end = 1'b1;
				end else begin
					if (n > 0) begin
						errors++;
						$display("data line after case %0d has only %0d fields", cases, n);
					end
					got = $fgets(rest, fd); // comment line
					if (got == 0) begin
						at_end = 1'b1;
					end
				end
			end
			$fclose(fd);
			if (cases == 0) begin
				errors++;
				$display("no test cases were read from the data file");
			end
		end

		$display("cases %0d checks %0d errors %0d", cases, checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mul_unit #(
	parameter int XLEN = 64
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              start,
	input  mul_pkg::mul_req_t req,
	input  logic [XLEN-1:0]   src_a,
	input  logic [XLEN-1:0]   src_b,
	output logic              busy,
	output logic              done,
	output logic [XLEN-1:0]   result
);

	logic              go;
	mul_pkg::mul_op_t  op;
	logic [2*XLEN-1:0] product;
	logic              prod_done;

	assign go = start & ~busy; // start while busy is dropped

	mul_decode u_decode (
		.clk     (clk),
		.rst_n   (rst_n),
		.go      (go),
		.req     (req),
		.op      (op),
		.illegal ()       // no trap path in this block
	);

	booth_mul #(
		.XLEN (XLEN)
	) u_booth (
		.clk       (clk),
		.rst_n     (rst_n),
		.go        (go),
		.src_a     (src_a),
		.src_b     (src_b),
		.op        (op),
		.busy      (busy),
		.product   (product),
		.prod_done (prod_done)
	);

	mul_result #(
		.XLEN (XLEN)
	) u_result (
		.clk       (clk),
		.rst_n     (rst_n),
		.prod_done (prod_done),
		.product   (product),
		.op        (op),
		.done      (done),
		.result    (result)
	);

endmodule

`default_nettype wire

// File: logic/mul_result.sv
`timescale 1ns/1ps
`default_nettype none

module mul_result #(
	parameter int XLEN = 64
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              prod_done,
	input  logic [2*XLEN-1:0] product,
	input  mul_pkg::mul_op_t  op,
	output logic              done,
	output logic [XLEN-1:0]   result
);

	logic [XLEN-1:0] sel;

	// op stays put from decode until the next accepted start
	always_comb begin
		if (op.word) begin
			sel = XLEN'($signed(product[31:0])); // MULW
		end else if (op.kind == mul_pkg::lo) begin
			sel = product[XLEN-1:0];
		end else begin
			sel = product[2*XLEN-1:XLEN];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			done   <= 1'b0;
			result <= '0;
		end else begin
			done <= prod_done;
			if (prod_done) begin
				result <= sel;
			end
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) $rose(done) |-> $past(prod_done))
		else $error("mul_result: done without prod_done");

endmodule

`default_nettype wire

// File: logic/booth_mul.sv
`timescale 1ns/1ps
`default_nettype none

module booth_mul #(
	parameter int XLEN = 64
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              go,
	input  logic [XLEN-1:0]   src_a,
	input  logic [XLEN-1:0]   src_b,
	input  mul_pkg::mul_op_t  op,
	output logic              busy,
	output logic [2*XLEN-1:0] product,
	output logic              prod_done
);

	localparam int K     = XLEN / 2 + 1; // steps over the XLEN+2 bit multiplier
	localparam int PW    = 2 * XLEN + 2; // multiplicand and partial sum
	localparam int MW    = XLEN + 3;     // multiplier with the implicit zero below bit 0
	localparam int CNT_W = $clog2(K);

	typedef enum logic [2:0] {
		st_idle,
		st_load,
		st_run,
		st_fin,  // product valid
		st_hold  // result stage shows done
	} state_e;

	state_e           state;
	logic [CNT_W-1:0] cnt;

	logic [XLEN-1:0]  a_q;
	logic [XLEN-1:0]  b_q;
	logic [XLEN-1:0]  a_w;
	logic [XLEN-1:0]  b_w;
	logic             a_neg;
	logic             b_neg;
	logic [PW-1:0]    a_ext;
	logic [XLEN+1:0]  b_ext;

	logic [PW-1:0]    mcand;
	logic [MW-1:0]    mplier;
	logic [PW-1:0]    psum;
	logic [PW-1:0]    addend;

	// operands taken on the accepting edge
	always_ff @(posedge clk) begin
		if (go) begin
			a_q <= src_a;
			b_q <= src_b;
		end
	end

	// op is valid from the cycle after go
	always_comb begin
		if (op.word) begin
			a_w = XLEN'($signed(a_q[31:0]));
			b_w = XLEN'($signed(b_q[31:0]));
		end else begin
			a_w = a_q;
			b_w = b_q;
		end
		a_neg = op.a_signed & a_w[XLEN-1];
		b_neg = mul_pkg::b_is_signed(op) & b_w[XLEN-1];
		a_ext = {{(XLEN + 2){a_neg}}, a_w};
		b_ext = {{2{b_neg}}, b_w};
	end

	// radix-4 recode of the low window
	always_comb begin
		case (mplier[2:0])
			3'b001, 3'b010: addend = mcand;
			3'b011:         addend = mcand << 1;
			3'b100:         addend = -(mcand << 1);
			3'b101, 3'b110: addend = -mcand;
			default:        addend = '0; // 000 and 111
		endcase
	end

	// fixed K steps, no early exit
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			cnt   <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (go) begin
						state <= st_load;
					end
				end
				st_load: begin
					state <= st_run;
					cnt   <= CNT_W'(K - 1);
				end
				st_run: begin
					if (cnt == '0) begin
						state <= st_fin;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				st_fin: begin
					state <= st_hold;
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_load) begin
			mcand  <= a_ext;
			mplier <= {b_ext, 1'b0};
			psum   <= '0;
		end else if (state == st_run) begin
			psum   <= psum + addend;
			mcand  <= mcand << 2;
			mplier <= {{2{mplier[MW-1]}}, mplier[MW-1:2]};
		end
	end

	assign busy      = (state != st_idle);
	assign prod_done = (state == st_fin);
	assign product   = psum[2*XLEN-1:0]; // upper two guard bits dropped

	// the top level must gate start with busy
	assert property (@(posedge clk) disable iff (!rst_n) go |-> !busy)
		else $error("booth_mul: go while busy");

	assert property (@(posedge clk) disable iff (!rst_n) prod_done |=> !prod_done)
		else $error("booth_mul: prod_done longer than one cycle");

endmodule

`default_nettype wire

// File: logic/mul_decode.sv
`timescale 1ns/1ps
`default_nettype none

module mul_decode (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              go,
	input  mul_pkg::mul_req_t req,
	output mul_pkg::mul_op_t  op,
	output logic              illegal
);

	mul_pkg::mul_kind_e kind_d;
	logic               bad_d;
	logic               a_signed_d;

	always_comb begin
		kind_d = mul_pkg::mul_kind_e'(req.funct3[1:0]);
		// funct3[2] is div/rem, not handled in this block
		bad_d = req.funct3[2] | (req.word & (kind_d != mul_pkg::lo));
		if (bad_d) begin
			kind_d = mul_pkg::lo; // falls back to the plain low word
		end
		a_signed_d = (kind_d == mul_pkg::hi_ss) | (kind_d == mul_pkg::hi_su);
	end

	// held until the next accepted start
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			op      <= '0;
			illegal <= 1'b0;
		end else if (go) begin
			op.kind     <= kind_d;
			op.word     <= req.word;
			op.a_signed <= a_signed_d;
			illegal     <= bad_d;
		end
	end

endmodule

`default_nettype wire

// File: logic/mul_pkg.sv
`default_nettype none

package mul_pkg;

	localparam int FUNCT3_W = 3;

	// funct3[1:0] of the multiply group
	typedef enum logic [1:0] {
		lo    = 2'b00, // MUL and MULW
		hi_ss = 2'b01, // MULH
		hi_su = 2'b10, // MULHSU
		hi_uu = 2'b11  // MULHU
	} mul_kind_e;

	typedef struct packed {
		mul_kind_e kind;
		logic      word;     // MULW form
		logic      a_signed;
	} mul_op_t;

	// raw instruction fields
	typedef struct packed {
		logic [FUNCT3_W-1:0] funct3;
		logic                word;
	} mul_req_t;

	// B is unsigned for MULHSU and MULHU only
	// lo takes signed since the low half is the same either way
	function automatic logic b_is_signed(mul_op_t op);
		logic s;
		s = (op.kind == hi_ss) || (op.kind == lo);
		return s;
	endfunction

endpackage

`default_nettype wire
